/* list.f */
+incdir+source
source/irqc_pkg.sv
source/irqc_msr_if.sv
source/irqc_core.sv
source/irqc_prio.sv
source/irqc_wb_regs.sv
source/irqc_top.sv
verification/irqc_tb_clock.sv
verification/irqc_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILE_LIST ?= list.f
TB_TOP    ?= irqc_tb
RTL_TOP   ?= irqc_top
BUILD_DIR ?= build
SIM_EXE   ?= $(TB_TOP)_sim
LOG       ?= sim.log
FAIL_MSG  ?= ERRORS FOUND
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_EXE)

sim: build
	@./$(BUILD_DIR)/$(SIM_EXE) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/irqc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "irqc_defines.svh"

module irqc_tb;

   localparam int CLK_NS      = 8;
   localparam int NUM_IRQ     = `IRQC_NUM_IRQ;
   localparam int ACK_LIMIT   = 8;
   localparam int N_SYNC      = 24;
   localparam int N_RAND      = 160;
   // Cycle budget with three edges per bus access
   localparam int TEST_CYCLES = 60 + N_SYNC * 8 + N_RAND * 12;
   localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_NS;

   logic                   clk;
   logic                   rst;
   irqc_pkg::lines_t       irqs;
   logic                   cyc;
   logic                   stb;
   logic                   we;
   logic [`IRQC_ADR_W-1:0] adr;
   irqc_pkg::word_t        dat_w;
   irqc_pkg::word_t        dat_r;
   logic                   ack;
   logic                   irq;

   // Two-stage delayed copy of the lines
   irqc_pkg::lines_t d1;
   irqc_pkg::lines_t d2;
   // Last written mask and enable
   irqc_pkg::word_t  imr_model;
   logic             ire_model;
   // Request in its first cycle before ack
   logic             pending;
   logic             exp_irq;
   logic [31:0]      lfsr;
   int               errs_proto = 0;
   int               errs_irq = 0;
   int               errs_read = 0;
   int               accesses = 0;
   int               irq_checks = 0;

   irqc_tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clock (
      .clk (clk),
      .rst (rst)
   );

   irqc_top u_irqc_top (
      .clk   (clk),
      .rst   (rst),
      .irqs  (irqs),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack),
      .irq   (irq)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic expect_irq(irqc_pkg::lines_t pend, irqc_pkg::word_t mask,
                                       logic en);
      return en & (|(pend & ~mask[NUM_IRQ-1:0]));
   endfunction

   // Downward scan so the last hit is the lowest line
   function automatic irqc_pkg::word_t expect_cause(irqc_pkg::lines_t pend);
      irqc_pkg::word_t c;
      c = '0;
      for (int i = NUM_IRQ - 1; i >= 0; i--) begin
         if (pend[i]) begin
            c = irqc_pkg::word_t'(i);
            c[irqc_pkg::CAUSE_VALID_BIT] = 1'b1;
         end
      end
      return c;
   endfunction

   // One LFSR step per bit
   task automatic draw_bits(input int n, output irqc_pkg::word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[`IRQC_DW-2:0], lfsr[0]};
      end
   endtask

   // Single Wishbone classic access held until ack
   task automatic bus_access(input logic wr, input logic [`IRQC_ADR_W-1:0] a,
                             input irqc_pkg::word_t wdata, output irqc_pkg::word_t rdata);
      int waited;
      waited = 0;
      @(posedge clk);
      cyc     <= 1'b1;
      stb     <= 1'b1;
      we      <= wr;
      adr     <= a;
      dat_w   <= wdata;
      pending <= 1'b1;
      @(posedge clk);
      pending <= 1'b0;
      while (ack !== 1'b1 && waited < ACK_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (ack !== 1'b1) begin
         errs_proto++;
         $display("Slave gave no ack within %0d cycles at %0t", ACK_LIMIT, $time);
      end
      rdata = dat_r;
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
      accesses++;
   endtask

   task automatic write_reg(input logic [`IRQC_ADR_W-1:0] a, input irqc_pkg::word_t data);
      irqc_pkg::word_t unused_rd;
      bus_access(1'b1, a, data, unused_rd);
   endtask

   task automatic check_read(input logic [`IRQC_ADR_W-1:0] a, input irqc_pkg::word_t expected,
                             input string name);
      irqc_pkg::word_t rd;
      bus_access(1'b0, a, '0, rd);
      assert (rd === expected) else begin
         errs_read++;
         $display("Mismatch at %0t: dat_r (%s) expected %h got %h", $time, name, expected, rd);
      end
   endtask

   // Model state where writes land with ack
   always @(posedge clk) begin
      if (rst) begin
         d1        <= '0;
         d2        <= '0;
         imr_model <= '1;
         ire_model <= 1'b0;
      end else begin
         d1 <= irqs;
         d2 <= d1;
         if (pending && we && adr == irqc_pkg::REG_IMR) imr_model <= dat_w;
         if (pending && we && adr == irqc_pkg::REG_PSR) ire_model <= dat_w[0];
      end
   end

   // New mask already counts in the strobe cycle
   always_comb begin
      if (pending && we && adr == irqc_pkg::REG_IMR) begin
         exp_irq = expect_irq(d2, dat_w, ire_model);
      end else begin
         exp_irq = expect_irq(d2, imr_model, ire_model);
      end
   end

   // irq compared mid-cycle in every cycle
   always @(negedge clk) begin
      if (!rst) begin
         irq_checks++;
         assert (irq === exp_irq) else begin
            errs_irq++;
            $display("Mismatch at %0t: irq expected %0b got %0b", $time, exp_irq, irq);
         end
      end
   end

   ack_after_req : assert property (@(posedge clk) disable iff (rst)
      (cyc && stb && !ack) |=> ack)
      else begin
         errs_proto++;
         $display("Mismatch at %0t: ack expected 1 got %0b", $time, $sampled(ack));
      end

   ack_one_cycle : assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else begin
         errs_proto++;
         $display("Mismatch at %0t: ack expected 0 got %0b", $time, $sampled(ack));
      end

   ack_needs_req : assert property (@(posedge clk) disable iff (rst) !(cyc && stb) |=> !ack)
      else begin
         errs_proto++;
         $display("Mismatch at %0t: ack expected 0 got %0b", $time, $sampled(ack));
      end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      irqc_pkg::word_t        v;
      irqc_pkg::word_t        m;
      irqc_pkg::lines_t       lines;
      irqc_pkg::lines_t       prev;
      logic [`IRQC_ADR_W-1:0] sel;
      int                     errs;
      lfsr    = 32'h08b5_982f;
      irqs    <= '0;
      cyc     <= 1'b0;
      stb     <= 1'b0;
      we      <= 1'b0;
      adr     <= '0;
      dat_w   <= '0;
      pending <= 1'b0;
      wait (rst === 1'b0);

      // Reset state
      @(negedge clk);
      assert (ack === 1'b0) else begin
         errs_proto++;
         $display("Mismatch at %0t: ack expected 0 got %0b", $time, ack);
      end
      check_read(irqc_pkg::REG_IMR, '1, "IMR");
      check_read(irqc_pkg::REG_PSR, '0, "PSR");
      check_read(irqc_pkg::REG_IRR, '0, "IRR");
      check_read(irqc_pkg::REG_CAUSE, '0, "CAUSE");

      // Writes to IRR and CAUSE have no effect
      draw_bits(NUM_IRQ, v);
      lines = v[NUM_IRQ-1:0];
      @(posedge clk);
      irqs <= lines;
      draw_bits(`IRQC_DW, m);
      write_reg(irqc_pkg::REG_IMR, m);
      write_reg(irqc_pkg::REG_PSR, 32'h1);
      draw_bits(`IRQC_DW, v);
      write_reg(irqc_pkg::REG_IRR, v);
      write_reg(irqc_pkg::REG_CAUSE, ~v);
      check_read(irqc_pkg::REG_IMR, m, "IMR");
      check_read(irqc_pkg::REG_IRR, irqc_pkg::word_t'(lines), "IRR");
      check_read(irqc_pkg::REG_PSR, 32'h1, "PSR");
      check_read(irqc_pkg::REG_CAUSE, expect_cause(lines & ~m[NUM_IRQ-1:0]), "CAUSE");

      // All lines up and enabled, irq flips inside each mask strobe
      @(posedge clk);
      irqs <= '1;
      write_reg(irqc_pkg::REG_IMR, '1);
      write_reg(irqc_pkg::REG_IMR, '0);
      write_reg(irqc_pkg::REG_IMR, '1);

      // Open mask so irq tracks the IRR directly
      write_reg(irqc_pkg::REG_IMR, '0);
      prev = '1;
      for (int n = 0; n < N_SYNC; n++) begin
         draw_bits(NUM_IRQ, v);
         lines = v[NUM_IRQ-1:0];
         @(posedge clk);
         irqs <= lines;
         // Captured on the second edge, still the old lines
         check_read(irqc_pkg::REG_IRR, irqc_pkg::word_t'(prev), "IRR old");
         check_read(irqc_pkg::REG_IRR, irqc_pkg::word_t'(lines), "IRR");
         prev = lines;
      end

      // Random lines, masks, enables and ignored writes
      for (int n = 0; n < N_RAND; n++) begin
         draw_bits(NUM_IRQ, v);
         lines = v[NUM_IRQ-1:0];
         @(posedge clk);
         irqs <= lines;
         draw_bits(`IRQC_ADR_W, v);
         sel = v[`IRQC_ADR_W-1:0];
         // Mostly masked so some cycles have nothing pending
         draw_bits(`IRQC_DW, m);
         draw_bits(`IRQC_DW, v);
         m = m | v;
         write_reg(sel, m);
         check_read(irqc_pkg::REG_CAUSE,
                    expect_cause(lines & ~imr_model[NUM_IRQ-1:0]), "CAUSE");
         case (sel)
            irqc_pkg::REG_IMR: v = imr_model;
            irqc_pkg::REG_PSR: v = irqc_pkg::word_t'(ire_model);
            irqc_pkg::REG_IRR: v = irqc_pkg::word_t'(lines);
            default:           v = expect_cause(lines & ~imr_model[NUM_IRQ-1:0]);
         endcase
         check_read(sel, v, "written reg");
      end

      errs = errs_proto + errs_irq + errs_read;
      $display("Summary: %0d accesses, %0d irq checks, errors proto %0d irq %0d read %0d",
               accesses, irq_checks, errs_proto, errs_irq, errs_read);
      if (errs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verification/irqc_tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module irqc_tb_clock #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst
);

   // Free-running clock, low first
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Sync reset, released on a rising edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

/* source/irqc_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "irqc_defines.svh"

module irqc_top (
   input  logic                   clk,
   input  logic                   rst,
   // Async interrupt lines
   input  irqc_pkg::lines_t       irqs,
   // Wishbone classic slave
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`IRQC_ADR_W-1:0] adr,
   input  irqc_pkg::word_t        dat_w,
   output irqc_pkg::word_t        dat_r,
   output logic                   ack,
   // Level interrupt to the CPU
   output logic                   irq
);

   // Pending and unmasked lines
   irqc_pkg::lines_t irq_masked;
   // Encoded cause word
   irqc_pkg::word_t  cause;

   // Mask, request and enable between slave and core
   irqc_msr_if u_msr ();

   irqc_core u_core (
      .clk        (clk),
      .rst        (rst),
      .irqs       (irqs),
      .msr        (u_msr.core),
      .irq_masked (irq_masked),
      .irq        (irq)
   );

   irqc_prio u_prio (
      .irq_masked (irq_masked),
      .cause      (cause)
   );

   irqc_wb_regs u_wb_regs (
      .clk   (clk),
      .rst   (rst),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (irqc_pkg::reg_e'(adr)),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack),
      .cause (cause),
      .msr   (u_msr.regs)
   );

endmodule

`default_nettype wire

/* source/irqc_wb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module irqc_wb_regs (
   input  logic             clk,
   input  logic             rst,
   // Wishbone classic slave
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  irqc_pkg::reg_e   adr,
   input  irqc_pkg::word_t  dat_w,
   output irqc_pkg::word_t  dat_r,
   output logic             ack,
   // Encoded cause from the priority picker
   input  irqc_pkg::word_t  cause,
   irqc_msr_if.regs         msr
);

   // Bus request seen
   logic            req;
   // Request not yet acked, one cycle per access
   logic            acc;
   // Write and read strobes
   logic            wr_stb;
   logic            rd_stb;
   // Registered handshake
   logic            ack_q;
   // Global enable bit
   logic            ire_q;
   // Read data, held for the ack cycle
   irqc_pkg::word_t dat_r_q;
   // Selected register value
   irqc_pkg::word_t rd_mux;

   assign req    = cyc & stb;
   assign acc    = req & ~ack_q;
   assign wr_stb = acc & we;
   assign rd_stb = acc & ~we;

   // Ack the cycle after the request, for one cycle only
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;
      end
   end

   // Mask write goes straight to the core
   assign msr.imr_we  = wr_stb & (adr == irqc_pkg::REG_IMR);
   assign msr.imr_nxt = dat_w;

   // Enable bit, lands on the edge where ack rises
   always_ff @(posedge clk) begin
      if (rst) begin
         ire_q <= 1'b0;
      end else if (wr_stb && adr == irqc_pkg::REG_PSR) begin
         ire_q <= dat_w[0];
      end
   end

   assign msr.ire = ire_q;

   // Register select
   // IRR and CAUSE writes have no target, so they fall through
   always_comb begin
      case (adr)
         irqc_pkg::REG_IMR:   rd_mux = msr.imr;
         irqc_pkg::REG_IRR:   rd_mux = msr.irr;
         irqc_pkg::REG_PSR:   rd_mux = irqc_pkg::word_t'(ire_q);
         irqc_pkg::REG_CAUSE: rd_mux = cause;
         default:             rd_mux = '0;
      endcase
   end

   // Capture on the request cycle
   always_ff @(posedge clk) begin
      if (rd_stb) begin
         dat_r_q <= rd_mux;
      end
   end

   assign dat_r = dat_r_q;
   assign ack   = ack_q;

endmodule

`default_nettype wire

/* source/irqc_prio.sv */
`timescale 1ns/1ns
`default_nettype none

`include "irqc_defines.svh"

module irqc_prio (
   input  irqc_pkg::lines_t irq_masked,
   output irqc_pkg::word_t  cause
);

   // Bits needed for a line index
   localparam int IDX_W = $clog2(`IRQC_NUM_IRQ);

   // Some line pending
   logic             found;
   // Lowest pending line
   logic [IDX_W-1:0] idx;

   // Scan upward, first hit wins
   always_comb begin
      found = 1'b0;
      idx   = '0;
      for (int i = 0; i < `IRQC_NUM_IRQ; i++) begin
         if (irq_masked[i] && !found) begin
            found = 1'b1;
            idx   = IDX_W'(i);
         end
      end
   end

   // Valid on top, index at the bottom, all zero when idle
   always_comb begin
      cause = '0;
      if (found) begin
         cause[irqc_pkg::CAUSE_VALID_BIT] = 1'b1;
         cause[IDX_W-1:0]                 = idx;
      end
   end

endmodule

`default_nettype wire

/* source/irqc_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "irqc_defines.svh"

module irqc_core (
   input  logic             clk,
   input  logic             rst,
   input  irqc_pkg::lines_t irqs,
   irqc_msr_if.core         msr,
   output irqc_pkg::lines_t irq_masked,
   output logic             irq
);

   // First synchronizer stage, may go metastable
   irqc_pkg::lines_t sync_q;
   // Second stage, this is the IRR
   irqc_pkg::lines_t irr_q;
   // Stored mask
   irqc_pkg::word_t  imr_q;

   // Two-flop synchronizer for the async lines
   always_ff @(posedge clk) begin
      if (rst) begin
         sync_q <= '0;
         irr_q  <= '0;
      end else begin
         sync_q <= irqs;
         irr_q  <= sync_q;
      end
   end

   // Mask register, everything masked out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         imr_q <= '1;
      end else if (msr.imr_we) begin
         imr_q <= msr.imr_nxt;
      end
   end

   // Bypass so a mask write acts in its own cycle
   assign msr.imr = msr.imr_we ? msr.imr_nxt : imr_q;

   // Upper IRR bits read as zero
   assign msr.irr = irqc_pkg::word_t'(irr_q);

   // Drop masked lines, only the line bits of IMR matter
   assign irq_masked = irr_q & ~msr.imr[`IRQC_NUM_IRQ-1:0];

   // Any unmasked request, gated by global enable
   assign irq = (|irq_masked) & msr.ire;

endmodule

`default_nettype wire

/* source/irqc_msr_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface irqc_msr_if;

   // Mask as seen by software and core, write already bypassed
   irqc_pkg::word_t imr;
   // New mask from the bus
   irqc_pkg::word_t imr_nxt;
   // One-cycle mask write strobe
   logic            imr_we;
   // Synchronized requests, zero-extended
   irqc_pkg::word_t irr;
   // Global interrupt enable
   logic            ire;

   // Register slave side
   modport regs (input imr, input irr, output imr_nxt, output imr_we, output ire);

   // Controller core side
   modport core (output imr, output irr, input imr_nxt, input imr_we, input ire);

endinterface

`default_nettype wire

/* source/irqc_pkg.sv */
`default_nettype none

`include "irqc_defines.svh"

package irqc_pkg;

   // One register word
   typedef logic [`IRQC_DW-1:0] word_t;

   // One bit per interrupt line
   typedef logic [`IRQC_NUM_IRQ-1:0] lines_t;

   // Register index on the Wishbone address
   typedef enum logic [`IRQC_ADR_W-1:0] {
      REG_IMR   = `IRQC_REG_IMR,
      REG_IRR   = `IRQC_REG_IRR,
      REG_PSR   = `IRQC_REG_PSR,
      REG_CAUSE = `IRQC_REG_CAUSE
   } reg_e;

   // Valid flag of the cause word, MSB
   localparam int CAUSE_VALID_BIT = `IRQC_DW - 1;

endpackage

`default_nettype wire

/* source/irqc_defines.svh */
`ifndef IRQC_DEFINES_SVH
`define IRQC_DEFINES_SVH

// Register and data width
`define IRQC_DW 32

// Number of external interrupt lines, not above IRQC_DW
`define IRQC_NUM_IRQ 16

// Wishbone word address width
`define IRQC_ADR_W 2

// Register word offsets
`define IRQC_REG_IMR 0
`define IRQC_REG_IRR 1
// Bit 0 holds the global enable
`define IRQC_REG_PSR 2
// Valid bit on top, line index in the low bits
`define IRQC_REG_CAUSE 3

`endif
